//--- flist.f
logic/md_width_pkg.sv
logic/md_op_pkg.sv
logic/md_unit_if.sv
logic/md_mult_fast.sv
logic/md_div_serial.sv
logic/md_ctrl.sv
logic/multdiv_top.sv
verif/multdiv_checker.sv
verif/multdiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the multiply/divide testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module multdiv_tb -o multdiv_sim

# The simulator may exit non-zero on failure, the log decides the result
./obj_dir/multdiv_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail"
  exit 1
fi

//--- verif/multdiv_tb.sv
// Self-checking testbench for the multiply/divide unit.
// Sends corner and LFSR-random requests under random back-pressure and
// compares each response in order against an arithmetic model.

`timescale 1ns/1ns
`default_nettype none

module multdiv_tb;

  localparam int          XLEN         = md_width_pkg::XLEN;
  localparam logic [31:0] LFSR_SEED    = 32'd31433;
  localparam int          NUM_DIRECTED = 256;
  localparam int          NUM_TXN      = 1256;
  localparam int          STALL_LIMIT  = 200;
  localparam int          DRAIN_CYCLES = 40;

  logic                rst_ni;
  logic                clk_i;
  logic                req_valid_i;
  logic                req_ready_o;
  md_op_pkg::md_op_e   req_op_i;
  md_op_pkg::md_sign_t req_sign_i;
  logic [XLEN-1:0]     req_a_i;
  logic [XLEN-1:0]     req_b_i;
  logic                rsp_valid_o;
  logic                rsp_ready_i;
  logic [XLEN-1:0]     rsp_data_o;

  logic [31:0]         lfsr_q;
  logic [XLEN-1:0]     exp_q[$];
  string               desc_q[$];

  multdiv_top multdiv_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_sign_i  (req_sign_i),
    .req_a_i     (req_a_i),
    .req_b_i     (req_b_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic logic [XLEN-1:0] corner_value(input logic [1:0] sel);
    case (sel)
      2'd0:    return '0;
      2'd1:    return 1;
      2'd2:    return '1;
      default: return {1'b1, {(XLEN-1){1'b0}}};
    endcase
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Expected results from 64-bit products and the RISC-V M division rules
  task automatic compute_expected(
    input  md_op_pkg::md_op_e   op,
    input  md_op_pkg::md_sign_t sign,
    input  logic [XLEN-1:0]     a,
    input  logic [XLEN-1:0]     b,
    output logic [XLEN-1:0]     res
  );
    logic signed [2*XLEN-1:0] wide_a;
    logic signed [2*XLEN-1:0] wide_b;
    logic signed [2*XLEN-1:0] wide_r;
    wide_a = sign[md_op_pkg::SIGN_A_BIT] ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    wide_b = sign[md_op_pkg::SIGN_B_BIT] ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    wide_r = wide_a * wide_b;
    case (op)
      md_op_pkg::MD_OP_MULL: res = wide_r[XLEN-1:0];
      md_op_pkg::MD_OP_MULH: res = wide_r[2*XLEN-1:XLEN];
      md_op_pkg::MD_OP_DIV: begin
        if (b == '0) begin
          res = '1;
        end else begin
          // Signed 64-bit division truncates toward zero
          wide_r = wide_a / wide_b;
          res    = wide_r[XLEN-1:0];
        end
      end
      default: begin
        wide_r = (b == '0) ? wide_a : wide_a % wide_b;
        res    = wide_r[XLEN-1:0];
      end
    endcase
  endtask

  // Directed corners come first and random operands follow with a bias toward small divisors
  task automatic build_request(input int idx);
    logic [31:0] rnd;
    if (idx < NUM_DIRECTED) begin
      req_a_i    = corner_value(idx[1:0]);
      req_b_i    = corner_value(idx[3:2]);
      req_op_i   = md_op_pkg::md_op_e'(idx[5:4]);
      req_sign_i = idx[7:6];
    end else begin
      rnd        = take_bits(2);
      req_op_i   = md_op_pkg::md_op_e'(rnd[1:0]);
      rnd        = take_bits(2);
      req_sign_i = rnd[1:0];
      req_a_i    = take_bits(XLEN);
      rnd        = take_bits(3);
      if (rnd[2:0] == 3'd0) begin
        req_b_i = '0;
      end else if (rnd[2:0] == 3'd1) begin
        req_b_i = take_bits(4);
      end else begin
        req_b_i = take_bits(XLEN);
      end
    end
  endtask

  initial begin
    int              sent;
    int              recv;
    int              stall;
    logic            req_fire;
    logic [31:0]     rnd;
    logic [XLEN-1:0] exp;
    string           desc;

    lfsr_q      = LFSR_SEED;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = md_op_pkg::MD_OP_MULL;
    req_sign_i  = '0;
    req_a_i     = '0;
    req_b_i     = '0;
    rsp_ready_i = 1'b0;
    sent        = 0;
    recv        = 0;
    stall       = 0;
    req_fire    = 1'b0;

    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    // One pass per cycle with inputs changed only on the falling edge
    while (recv < NUM_TXN) begin
      @(negedge clk_i);
      stall++;
      if (req_fire) begin
        req_valid_i = 1'b0;
        req_fire    = 1'b0;
      end
      rnd = take_bits(1);
      if (!req_valid_i && (sent < NUM_TXN) && rnd[0]) begin
        build_request(sent);
        req_valid_i = 1'b1;
      end
      // Transfers on the next rising edge
      if (req_valid_i && req_ready_o) begin
        compute_expected(req_op_i, req_sign_i, req_a_i, req_b_i, exp);
        exp_q.push_back(exp);
        desc_q.push_back($sformatf("op %0d sign 0x%0h a 0x%08h b 0x%08h",
                                   req_op_i, req_sign_i, req_a_i, req_b_i));
        req_fire = 1'b1;
        sent++;
        stall = 0;
      end
      rnd         = take_bits(2);
      rsp_ready_i = (rnd[1:0] != 2'b00);
      if (rsp_valid_o && rsp_ready_i) begin
        assert (exp_q.size() > 0)
          else stop_on_error("A response arrived with no request outstanding");
        exp  = exp_q.pop_front();
        desc = desc_q.pop_front();
        assert (rsp_data_o == exp)
          else stop_on_error($sformatf("Error: rsp_data_o = 0x%08h, expected 0x%08h, %s",
                                       rsp_data_o, exp, desc));
        recv++;
        stall = 0;
      end
      assert (stall < STALL_LIMIT)
        else stop_on_error("Timeout: the handshakes made no progress for too many cycles");
    end

    // Nothing more may come out once every request has been answered
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    repeat (DRAIN_CYCLES) begin
      @(negedge clk_i);
      assert (!rsp_valid_o)
        else stop_on_error("An extra response appeared after the last request");
    end
    // Controller is back in idle and takes requests again
    assert (req_ready_o)
      else stop_on_error($sformatf("Error: req_ready_o = 0x%0h, expected 0x1",
                                   req_ready_o));

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/multdiv_checker.sv
// Concurrent handshake assertions for the multiply/divide top level.
// Attached to multdiv_top by the bind at the end of this file.

`timescale 1ns/1ns
`default_nettype none

module multdiv_checker (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          req_ready_i,
  input logic                          rsp_valid_i,
  input logic                          rsp_ready_i,
  input logic [md_width_pkg::XLEN-1:0] rsp_data_i,
  input logic                          mult_start_i,
  input logic                          div_start_i
);

  // Response holds until it is taken
  rsp_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_data_i))
  ) else $error("Response valid or data changed before the handshake");

  // No new request while a response waits
  ready_idle_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> !req_ready_i
  ) else $error("Request ready raised while a response is pending");

  // Only one unit starts at a time
  one_start_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(mult_start_i && div_start_i)
  ) else $error("Both units started in the same cycle");

endmodule

bind multdiv_top multdiv_checker multdiv_checker_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_ready_i  (req_ready_o),
  .rsp_valid_i  (rsp_valid_o),
  .rsp_ready_i  (rsp_ready_i),
  .rsp_data_i   (rsp_data_o),
  .mult_start_i (mult_bus.start),
  .div_start_i  (div_bus.start)
);

`default_nettype wire

//--- logic/multdiv_top.sv
// Top level of the iterative multiply/divide unit.
// One operation in flight at a time behind valid/ready request and
// response handshakes.

`timescale 1ns/1ns
`default_nettype none

module multdiv_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Request
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  md_op_pkg::md_op_e             req_op_i,
  input  md_op_pkg::md_sign_t           req_sign_i,
  input  logic [md_width_pkg::XLEN-1:0] req_a_i,
  input  logic [md_width_pkg::XLEN-1:0] req_b_i,

  // Response
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output logic [md_width_pkg::XLEN-1:0] rsp_data_o
);

  md_unit_if mult_bus ();
  md_unit_if div_bus ();

  md_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_sign_i  (req_sign_i),
    .req_a_i     (req_a_i),
    .req_b_i     (req_b_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o),
    .mult_bus    (mult_bus.ctrl),
    .div_bus     (div_bus.ctrl)
  );

  // MULL and MULH
  md_mult_fast u_mult (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (mult_bus.unit)
  );

  // DIV and REM
  md_div_serial u_div (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (div_bus.unit)
  );

endmodule

`default_nettype wire

//--- logic/md_ctrl.sv
// Request/response front end of the multiply/divide unit.
// Latches one request, starts the matching unit and holds the result
// until the response is taken.

`timescale 1ns/1ns
`default_nettype none

module md_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  md_op_pkg::md_op_e             req_op_i,
  input  md_op_pkg::md_sign_t           req_sign_i,
  input  logic [md_width_pkg::XLEN-1:0] req_a_i,
  input  logic [md_width_pkg::XLEN-1:0] req_b_i,
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output logic [md_width_pkg::XLEN-1:0] rsp_data_o,
  md_unit_if.ctrl                       mult_bus,
  md_unit_if.ctrl                       div_bus
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_RESP
  } ctrl_state_e;

  ctrl_state_e                   state_q;
  ctrl_state_e                   state_d;
  logic                          req_fire;
  logic                          req_is_mult;
  logic                          use_mult_q;
  logic                          mult_start_q;
  logic                          div_start_q;
  md_op_pkg::md_op_e             op_q;
  md_op_pkg::md_sign_t           sign_q;
  logic [md_width_pkg::XLEN-1:0] a_q;
  logic [md_width_pkg::XLEN-1:0] b_q;
  logic                          unit_done;
  logic [md_width_pkg::XLEN-1:0] unit_result;
  logic [md_width_pkg::XLEN-1:0] rsp_data_q;

  assign req_ready_o = (state_q == ST_IDLE);
  assign req_fire    = req_valid_i & req_ready_o;

  // Operation class, the only place that tells multiply from divide
  assign req_is_mult = (req_op_i == md_op_pkg::MD_OP_MULL) ||
                       (req_op_i == md_op_pkg::MD_OP_MULH);

  assign unit_done   = use_mult_q ? mult_bus.done : div_bus.done;
  assign unit_result = use_mult_q ? mult_bus.result : div_bus.result;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (req_fire) state_d = ST_BUSY;
      ST_BUSY: if (unit_done) state_d = ST_RESP;
      ST_RESP: if (rsp_ready_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      use_mult_q   <= 1'b0;
      mult_start_q <= 1'b0;
      div_start_q  <= 1'b0;
    end else begin
      state_q      <= state_d;
      mult_start_q <= req_fire & req_is_mult;
      div_start_q  <= req_fire & ~req_is_mult;
      if (req_fire) begin
        use_mult_q <= req_is_mult;
      end
    end
  end

  // Operands stay put from start until done, response holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q   <= req_op_i;
      sign_q <= req_sign_i;
      a_q    <= req_a_i;
      b_q    <= req_b_i;
    end
    if ((state_q == ST_BUSY) && unit_done) begin
      rsp_data_q <= unit_result;
    end
  end

  assign rsp_valid_o = (state_q == ST_RESP);
  assign rsp_data_o  = rsp_data_q;

  assign mult_bus.start = mult_start_q;
  assign mult_bus.op    = op_q;
  assign mult_bus.sign  = sign_q;
  assign mult_bus.op_a  = a_q;
  assign mult_bus.op_b  = b_q;

  assign div_bus.start  = div_start_q;
  assign div_bus.op     = op_q;
  assign div_bus.sign   = sign_q;
  assign div_bus.op_a   = a_q;
  assign div_bus.op_b   = b_q;

endmodule

`default_nettype wire

//--- logic/md_div_serial.sv
// Restoring long divider for DIV and REM.
// Works on absolute values for 32 steps and fixes the sign at the end;
// a zero divisor returns early with the RISC-V defined result.

`timescale 1ns/1ns
`default_nettype none

module md_div_serial (
  input  logic   clk_i,
  input  logic   rst_ni,
  md_unit_if.unit bus
);

  typedef enum logic [2:0] {
    DV_IDLE,
    DV_ABS_A,
    DV_ABS_B,
    DV_COMP,
    DV_LAST,
    DV_SIGN,
    DV_FINISH
  } div_state_e;

  div_state_e                      state_q;
  div_state_e                      state_d;
  logic [md_width_pkg::CNT_W-1:0]  cnt_q;
  logic [md_width_pkg::CNT_W-1:0]  cnt_d;
  logic [md_width_pkg::CNT_W-1:0]  cnt_dec;
  logic                            dbz_q;
  logic                            dbz_d;
  logic [md_width_pkg::XLEN-1:0]   rem_q;
  logic [md_width_pkg::XLEN-1:0]   rem_d;
  logic [md_width_pkg::XLEN-1:0]   quot_q;
  logic [md_width_pkg::XLEN-1:0]   quot_d;
  logic [md_width_pkg::XLEN-1:0]   num_q;
  logic [md_width_pkg::XLEN-1:0]   num_d;
  logic [md_width_pkg::XLEN-1:0]   den_q;
  logic [md_width_pkg::XLEN-1:0]   den_d;
  logic [md_width_pkg::XLEN-1:0]   sub_a;
  logic [md_width_pkg::XLEN-1:0]   sub_b;
  logic [md_width_pkg::XLEN:0]     sub_res;
  logic [md_width_pkg::XLEN-1:0]   next_rem;
  logic                            is_ge;
  logic                            is_div;
  logic                            sign_a;
  logic                            sign_b;
  logic                            change_sign;

  assign is_div = (bus.op == md_op_pkg::MD_OP_DIV);
  assign sign_a = bus.sign[md_op_pkg::SIGN_A_BIT] & bus.op_a[md_width_pkg::XLEN-1];
  assign sign_b = bus.sign[md_op_pkg::SIGN_B_BIT] & bus.op_b[md_width_pkg::XLEN-1];

  // Quotient is negated when the signs differ, remainder follows a
  assign change_sign = is_div ? (sign_a ^ sign_b) : sign_a;

  // Shared subtractor, the extra top bit is the borrow
  assign sub_res  = {1'b0, sub_a} - {1'b0, sub_b};
  assign is_ge    = ~sub_res[md_width_pkg::XLEN];
  assign next_rem = is_ge ? sub_res[md_width_pkg::XLEN-1:0] : rem_q;
  assign cnt_dec  = cnt_q - 1'b1;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    dbz_d   = dbz_q;
    rem_d   = rem_q;
    quot_d  = quot_q;
    num_d   = num_q;
    den_d   = den_q;
    sub_a   = '0;
    sub_b   = rem_q;
    case (state_q)
      DV_IDLE: begin
        if (bus.start) begin
          // Preload the divide-by-zero answer
          dbz_d   = (bus.op_b == '0);
          rem_d   = is_div ? '1 : bus.op_a;
          state_d = DV_ABS_A;
        end
      end
      DV_ABS_A: begin
        sub_b   = bus.op_a;
        num_d   = sign_a ? sub_res[md_width_pkg::XLEN-1:0] : bus.op_a;
        quot_d  = '0;
        state_d = dbz_q ? DV_FINISH : DV_ABS_B;
      end
      DV_ABS_B: begin
        sub_b   = bus.op_b;
        den_d   = sign_b ? sub_res[md_width_pkg::XLEN-1:0] : bus.op_b;
        rem_d   = {{(md_width_pkg::XLEN-1){1'b0}}, num_q[md_width_pkg::XLEN-1]};
        cnt_d   = '1;
        state_d = DV_COMP;
      end
      DV_COMP: begin
        sub_a   = rem_q;
        sub_b   = den_q;
        quot_d  = {quot_q[md_width_pkg::XLEN-2:0], is_ge};
        // Remainder stays below the divisor, so its top bit is free for the shift
        rem_d   = {next_rem[md_width_pkg::XLEN-2:0], num_q[cnt_dec]};
        cnt_d   = cnt_dec;
        state_d = (cnt_q == 1) ? DV_LAST : DV_COMP;
      end
      DV_LAST: begin
        sub_a   = rem_q;
        sub_b   = den_q;
        rem_d   = is_div ? {quot_q[md_width_pkg::XLEN-2:0], is_ge} : next_rem;
        state_d = DV_SIGN;
      end
      DV_SIGN: begin
        rem_d   = change_sign ? sub_res[md_width_pkg::XLEN-1:0] : rem_q;
        state_d = DV_FINISH;
      end
      DV_FINISH: state_d = DV_IDLE;
      default:   state_d = DV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= DV_IDLE;
      cnt_q   <= '0;
      dbz_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      dbz_q   <= dbz_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rem_q  <= rem_d;
    quot_q <= quot_d;
    num_q  <= num_d;
    den_q  <= den_d;
  end

  assign bus.done   = (state_q == DV_FINISH);
  assign bus.result = rem_q;

endmodule

`default_nettype wire

//--- logic/md_mult_fast.sv
// Iterative multiplier built around one signed 17x17 multiply-accumulate.
// MULL finishes after three partial products, MULH after four.

`timescale 1ns/1ns
`default_nettype none

module md_mult_fast (
  input  logic   clk_i,
  input  logic   rst_ni,
  md_unit_if.unit bus
);

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e                             state_q;
  mult_state_e                             state_d;
  logic [md_width_pkg::HALF_W-1:0]         mult_op_a;
  logic [md_width_pkg::HALF_W-1:0]         mult_op_b;
  logic                                    mult_sign_a;
  logic                                    mult_sign_b;
  logic [md_width_pkg::ACC_W-1:0]          accum;
  logic signed [md_width_pkg::ACC_W-1:0]   mac_res;
  logic [md_width_pkg::ACC_W-1:0]          acc_q;
  logic [md_width_pkg::ACC_W-1:0]          acc_d;
  logic [md_width_pkg::ACC_W-md_width_pkg::HALF_W-1:0] acc_shr;
  logic                                    signed_mult;
  logic                                    is_mull;
  logic                                    done_q;
  logic                                    done_d;

  assign is_mull     = (bus.op == md_op_pkg::MD_OP_MULL);
  assign signed_mult = (bus.sign != 2'b00);

  // Carry of the low partial product, always unsigned
  assign acc_shr = {{(md_width_pkg::ACC_W - 2 * md_width_pkg::HALF_W){1'b0}},
                    acc_q[2*md_width_pkg::HALF_W-1:md_width_pkg::HALF_W]};

  // Top two bits of the sum always agree, so the 34-bit wrap is harmless
  assign mac_res = $signed({mult_sign_a, mult_op_a}) * $signed({mult_sign_b, mult_op_b}) +
                   $signed(accum);

  always_comb begin
    mult_op_a   = bus.op_a[md_width_pkg::HALF_W-1:0];
    mult_op_b   = bus.op_b[md_width_pkg::HALF_W-1:0];
    mult_sign_a = 1'b0;
    mult_sign_b = 1'b0;
    accum       = '0;
    acc_d       = acc_q;
    state_d     = state_q;
    done_d      = 1'b0;
    case (state_q)
      ALBL: begin
        // Also the idle state, waits here for start
        if (bus.start) begin
          acc_d   = mac_res;
          state_d = ALBH;
        end
      end
      ALBH: begin
        mult_op_b   = bus.op_b[md_width_pkg::XLEN-1:md_width_pkg::HALF_W];
        mult_sign_b = bus.sign[md_op_pkg::SIGN_B_BIT] & bus.op_b[md_width_pkg::XLEN-1];
        accum       = acc_shr;
        if (is_mull) begin
          acc_d = {2'b00, mac_res[md_width_pkg::HALF_W-1:0],
                   acc_q[md_width_pkg::HALF_W-1:0]};
        end else begin
          acc_d = mac_res;
        end
        state_d = AHBL;
      end
      AHBL: begin
        mult_op_a   = bus.op_a[md_width_pkg::XLEN-1:md_width_pkg::HALF_W];
        mult_sign_a = bus.sign[md_op_pkg::SIGN_A_BIT] & bus.op_a[md_width_pkg::XLEN-1];
        if (is_mull) begin
          // Low word complete, upper bits are never needed
          accum   = acc_shr;
          acc_d   = {2'b00, mac_res[md_width_pkg::HALF_W-1:0],
                     acc_q[md_width_pkg::HALF_W-1:0]};
          done_d  = 1'b1;
          state_d = ALBL;
        end else begin
          accum   = acc_q;
          acc_d   = mac_res;
          state_d = AHBH;
        end
      end
      AHBH: begin
        mult_op_a   = bus.op_a[md_width_pkg::XLEN-1:md_width_pkg::HALF_W];
        mult_op_b   = bus.op_b[md_width_pkg::XLEN-1:md_width_pkg::HALF_W];
        mult_sign_a = bus.sign[md_op_pkg::SIGN_A_BIT] & bus.op_a[md_width_pkg::XLEN-1];
        mult_sign_b = bus.sign[md_op_pkg::SIGN_B_BIT] & bus.op_b[md_width_pkg::XLEN-1];
        accum   = {{md_width_pkg::HALF_W{signed_mult & acc_q[md_width_pkg::ACC_W-1]}},
                   acc_q[md_width_pkg::ACC_W-1:md_width_pkg::HALF_W]};
        acc_d   = mac_res;
        done_d  = 1'b1;
        state_d = ALBL;
      end
      default: state_d = ALBL;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  assign bus.done   = done_q;
  assign bus.result = acc_q[md_width_pkg::XLEN-1:0];

endmodule

`default_nettype wire

//--- logic/md_unit_if.sv
// Link between the controller and one arithmetic unit.
// The controller pulses start with stable operands, the unit pulses done
// with its result.

`timescale 1ns/1ns
`default_nettype none

interface md_unit_if;

  // Controller to unit
  logic                             start;
  md_op_pkg::md_op_e                op;
  md_op_pkg::md_sign_t              sign;
  logic [md_width_pkg::XLEN-1:0]    op_a;
  logic [md_width_pkg::XLEN-1:0]    op_b;

  // Unit to controller
  logic                             done;
  logic [md_width_pkg::XLEN-1:0]    result;

  modport ctrl (
    output start,
    output op,
    output sign,
    output op_a,
    output op_b,
    input  done,
    input  result
  );

  modport unit (
    input  start,
    input  op,
    input  sign,
    input  op_a,
    input  op_b,
    output done,
    output result
  );

endinterface

`default_nettype wire

//--- logic/md_op_pkg.sv
// Operation encoding and operand signedness for the multiply/divide unit.
// Shared by the controller, both arithmetic units and the testbench.

`default_nettype none

package md_op_pkg;

  // Operation requested at the top-level request port
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Per-operand signedness
  // Bit 0 marks operand a as signed, bit 1 marks operand b as signed
  typedef logic [1:0] md_sign_t;

  // Bit positions inside md_sign_t
  localparam int SIGN_A_BIT = 0;
  localparam int SIGN_B_BIT = 1;

endpackage

`default_nettype wire

//--- logic/md_width_pkg.sv
// Datapath widths shared by the multiply/divide unit.
// Modules refer to these through scoped names.

`default_nettype none

package md_width_pkg;

  // Operand and result width
  localparam int XLEN = 32;

  // Operand half fed to the 17x17 multiplier
  localparam int HALF_W = 16;

  // MAC result and accumulator, two guard bits above XLEN
  localparam int ACC_W = 34;

  // Division step counter, indexes bits 31 down to 0
  localparam int CNT_W = 5;

endpackage

`default_nettype wire
